/* hdl/riscv_isa_pkg.sv */
package riscv_isa_pkg;

  localparam int XLEN_W     = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // Load/store width field
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100; // Loads only
  localparam logic [2:0] F3_HU = 3'b101;

endpackage

/* hdl/lsu_pkg.sv */
package lsu_pkg;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } size_t;

  typedef enum logic {
    SIGN_U = 1'b0,
    SIGN_S = 1'b1
  } sign_t;

  // Decoded control carried down the pipe
  typedef struct packed {
    size_t size;
    sign_t sign;
    logic  is_load;
    logic  is_store;
  } lsu_ctrl_t;

endpackage

/* hdl/lsu_decoder.sv */
`timescale 1ns/1ns

module lsu_decoder (
  input  logic [riscv_isa_pkg::XLEN_W-1:0]     i_inst,
  output lsu_pkg::lsu_ctrl_t                   o_ctrl,
  output logic [riscv_isa_pkg::XLEN_W-1:0]     o_imm,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] o_rs1,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] o_rs2,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0] o_rd
);

  logic [6:0]                          w_opcode;
  logic [2:0]                          w_funct3;
  logic                                w_f3_ok;
  logic [riscv_isa_pkg::XLEN_W-1:0]    w_imm_i;
  logic [riscv_isa_pkg::XLEN_W-1:0]    w_imm_s;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];
  assign o_rd     = i_inst[11:7];
  assign o_rs1    = i_inst[19:15];
  assign o_rs2    = i_inst[24:20];

  assign w_imm_i = {{(riscv_isa_pkg::XLEN_W-12){i_inst[31]}}, i_inst[31:20]};
  assign w_imm_s = {{(riscv_isa_pkg::XLEN_W-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};

  always_comb begin
    w_f3_ok     = 1'b1;
    o_ctrl.size = lsu_pkg::SIZE_W;
    case (w_funct3)
      riscv_isa_pkg::F3_B, riscv_isa_pkg::F3_BU: o_ctrl.size = lsu_pkg::SIZE_B;
      riscv_isa_pkg::F3_H, riscv_isa_pkg::F3_HU: o_ctrl.size = lsu_pkg::SIZE_H;
      riscv_isa_pkg::F3_W:                       o_ctrl.size = lsu_pkg::SIZE_W;
      default:                                   w_f3_ok     = 1'b0;
    endcase
    o_ctrl.sign     = w_funct3[2] ? lsu_pkg::SIGN_U : lsu_pkg::SIGN_S;
    o_ctrl.is_load  = w_f3_ok && (w_opcode == riscv_isa_pkg::OPC_LOAD);
    // No unsigned stores
    o_ctrl.is_store = w_f3_ok && !w_funct3[2] && (w_opcode == riscv_isa_pkg::OPC_STORE);
  end

  assign o_imm = (w_opcode == riscv_isa_pkg::OPC_STORE) ? w_imm_s : w_imm_i;

endmodule

/* hdl/lsu_regfile.sv */
`timescale 1ns/1ns

module lsu_regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] i_rd1_addr,
  output logic [riscv_isa_pkg::XLEN_W-1:0]     o_rd1_data,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] i_rd2_addr,
  output logic [riscv_isa_pkg::XLEN_W-1:0]     o_rd2_data,
  input  logic                                 i_wr0_valid,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] i_wr0_addr,
  input  logic [riscv_isa_pkg::XLEN_W-1:0]     i_wr0_data,
  input  logic                                 i_wr1_valid,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] i_wr1_addr,
  input  logic [riscv_isa_pkg::XLEN_W-1:0]     i_wr1_data
);

  logic [riscv_isa_pkg::XLEN_W-1:0] r_regs [NUM_REGS];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      if (i_wr1_valid) begin
        r_regs[i_wr1_addr] <= i_wr1_data;
      end
      if (i_wr0_valid) begin
        r_regs[i_wr0_addr] <= i_wr0_data; // LSU writeback wins
      end
    end
  end

  // Write-through read, x0 reads zero
  function automatic logic [riscv_isa_pkg::XLEN_W-1:0] read_port(
    input logic [riscv_isa_pkg::REG_ADDR_W-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (i_wr0_valid && i_wr0_addr == addr) begin
      return i_wr0_data;
    end else if (i_wr1_valid && i_wr1_addr == addr) begin
      return i_wr1_data;
    end
    return r_regs[addr];
  endfunction

  always_comb begin
    o_rd1_data = read_port(i_rd1_addr);
    o_rd2_data = read_port(i_rd2_addr);
  end

  // Seeding must stay off registers a load is about to write
  a_no_dual_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_wr0_valid && i_wr1_valid && i_wr0_addr == i_wr1_addr && i_wr0_addr != '0));

endmodule

/* hdl/lsu_dmem.sv */
`timescale 1ns/1ns

module lsu_dmem #(
  parameter  int DMEM_WORDS = 64,
  localparam int AW         = $clog2(DMEM_WORDS)
) (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_rd_en,
  input  logic [AW-1:0]                       i_rd_addr,
  output logic [riscv_isa_pkg::XLEN_W-1:0]    o_rd_data,
  input  logic                                i_wr_en,
  input  logic [AW-1:0]                       i_wr_addr,
  input  logic [riscv_isa_pkg::XLEN_W/8-1:0]  i_wr_be,
  input  logic [riscv_isa_pkg::XLEN_W-1:0]    i_wr_data
);

  logic [riscv_isa_pkg::XLEN_W-1:0] r_mem [DMEM_WORDS];

  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      o_rd_data <= r_mem[i_rd_addr]; // Old word on a same-edge write
    end
    if (i_wr_en) begin
      for (int b = 0; b < riscv_isa_pkg::XLEN_W / 8; b++) begin
        if (i_wr_be[b]) begin
          r_mem[i_wr_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
      end
    end
  end

  a_wr_be_nonzero: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_en |-> i_wr_be != '0);

endmodule

/* hdl/lsu_pipe.sv */
`timescale 1ns/1ns

module lsu_pipe #(
  parameter  int DMEM_WORDS = 64,
  localparam int AW         = $clog2(DMEM_WORDS),
  localparam int XW         = riscv_isa_pkg::XLEN_W,
  localparam int RW         = riscv_isa_pkg::REG_ADDR_W
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_issue_valid,
  input  logic [XW-1:0]      i_issue_inst,
  output logic [XW-1:0]      o_dec_inst,
  input  lsu_pkg::lsu_ctrl_t i_dec_ctrl,
  input  logic [XW-1:0]      i_dec_imm,
  input  logic [RW-1:0]      i_dec_rs1,
  input  logic [RW-1:0]      i_dec_rs2,
  input  logic [RW-1:0]      i_dec_rd,
  output logic [RW-1:0]      o_rs1_addr,
  input  logic [XW-1:0]      i_rs1_data,
  output logic [RW-1:0]      o_rs2_addr,
  input  logic [XW-1:0]      i_rs2_data,
  output logic               o_mem_rd_en,
  output logic [AW-1:0]      o_mem_rd_addr,
  input  logic [XW-1:0]      i_mem_rd_data,
  output logic               o_mem_wr_en,
  output logic [AW-1:0]      o_mem_wr_addr,
  output logic [XW/8-1:0]    o_mem_wr_be,
  output logic [XW-1:0]      o_mem_wr_data,
  output logic               o_wb_valid,
  output logic [RW-1:0]      o_wb_rd,
  output logic [XW-1:0]      o_wb_data,
  output logic               o_exc_valid,
  output logic [XW-1:0]      o_exc_addr
);

  logic               r_ex0_valid;
  logic [XW-1:0]      r_ex0_inst;

  logic               r_ex1_valid;
  lsu_pkg::lsu_ctrl_t r_ex1_ctrl;
  logic [XW-1:0]      r_ex1_imm;
  logic [RW-1:0]      r_ex1_rs1;
  logic [RW-1:0]      r_ex1_rs2;
  logic [RW-1:0]      r_ex1_rd;
  logic [XW-1:0]      w_ex1_rs1_val;
  logic [XW-1:0]      w_ex1_rs2_val;
  logic [XW-1:0]      w_ex1_addr;
  logic [XW/8-1:0]    w_ex1_be;
  logic               w_ex1_misal;
  logic               w_ex1_fwd_hit;

  logic               r_ex2_valid;
  lsu_pkg::lsu_ctrl_t r_ex2_ctrl;
  logic [RW-1:0]      r_ex2_rd;
  logic [XW-1:0]      r_ex2_addr;
  logic [XW/8-1:0]    r_ex2_be;
  logic [XW-1:0]      r_ex2_st_data;
  logic               r_ex2_misal;
  logic [XW/8-1:0]    r_ex2_fwd_be;
  logic [XW-1:0]      r_ex2_fwd_data;
  logic               w_ex2_ld_ok;
  logic               w_ex2_sx;
  logic [XW-1:0]      w_ex2_merged;
  logic [XW-1:0]      w_ex2_shifted;
  logic [XW-1:0]      w_ex2_result;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid <= 1'b0;
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      o_wb_valid  <= 1'b0;
      o_exc_valid <= 1'b0;
    end else begin
      r_ex0_valid <= i_issue_valid;
      r_ex1_valid <= r_ex0_valid;
      r_ex2_valid <= r_ex1_valid;
      o_wb_valid  <= w_ex2_ld_ok;
      o_exc_valid <= r_ex2_valid & r_ex2_misal;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex0_inst     <= i_issue_inst;
    r_ex1_ctrl     <= i_dec_ctrl;
    r_ex1_imm      <= i_dec_imm;
    r_ex1_rs1      <= i_dec_rs1;
    r_ex1_rs2      <= i_dec_rs2;
    r_ex1_rd       <= i_dec_rd;
    r_ex2_ctrl     <= r_ex1_ctrl;
    r_ex2_rd       <= r_ex1_rd;
    r_ex2_addr     <= w_ex1_addr;
    r_ex2_be       <= w_ex1_be;
    r_ex2_st_data  <= w_ex1_rs2_val << {w_ex1_addr[1:0], 3'b000}; // Into its lanes
    r_ex2_misal    <= w_ex1_misal;
    r_ex2_fwd_be   <= w_ex1_fwd_hit ? r_ex2_be : '0;
    r_ex2_fwd_data <= r_ex2_st_data;
    o_wb_rd        <= r_ex2_rd;
    o_wb_data      <= w_ex2_result;
    o_exc_addr     <= r_ex2_addr;
  end

  assign o_dec_inst = r_ex0_inst;
  assign o_rs1_addr = r_ex1_rs1;
  assign o_rs2_addr = r_ex1_rs2;

  // Youngest producer first
  function automatic logic [XW-1:0] bypass(input logic [RW-1:0] rs, input logic [XW-1:0] rf);
    if (rs != '0 && w_ex2_ld_ok && r_ex2_rd == rs) begin
      return w_ex2_result;
    end else if (rs != '0 && o_wb_valid && o_wb_rd == rs) begin
      return o_wb_data;
    end
    return rf;
  endfunction

  always_comb begin
    w_ex1_rs1_val = bypass(r_ex1_rs1, i_rs1_data);
    w_ex1_rs2_val = bypass(r_ex1_rs2, i_rs2_data);
    w_ex1_addr    = w_ex1_rs1_val + r_ex1_imm;
    case (r_ex1_ctrl.size)
      lsu_pkg::SIZE_B: w_ex1_be = 4'b0001 << w_ex1_addr[1:0];
      lsu_pkg::SIZE_H: w_ex1_be = 4'b0011 << {w_ex1_addr[1], 1'b0};
      default:         w_ex1_be = 4'b1111;
    endcase
    w_ex1_misal = (r_ex1_ctrl.is_load || r_ex1_ctrl.is_store) &&
                  ((r_ex1_ctrl.size == lsu_pkg::SIZE_H && w_ex1_addr[0]) ||
                   (r_ex1_ctrl.size == lsu_pkg::SIZE_W && w_ex1_addr[1:0] != 2'b00));
  end

  // Store ahead writes this word on the same edge the load reads it
  assign w_ex1_fwd_hit = o_mem_wr_en && r_ex1_valid && r_ex1_ctrl.is_load &&
                         (r_ex2_addr[AW+1:2] == w_ex1_addr[AW+1:2]);

  assign o_mem_rd_en   = r_ex1_valid & r_ex1_ctrl.is_load;
  assign o_mem_rd_addr = w_ex1_addr[AW+1:2];

  assign o_mem_wr_en   = r_ex2_valid & r_ex2_ctrl.is_store & !r_ex2_misal;
  assign o_mem_wr_addr = r_ex2_addr[AW+1:2];
  assign o_mem_wr_be   = r_ex2_be;
  assign o_mem_wr_data = r_ex2_st_data;

  assign w_ex2_ld_ok = r_ex2_valid & r_ex2_ctrl.is_load & !r_ex2_misal;
  assign w_ex2_sx    = (r_ex2_ctrl.sign == lsu_pkg::SIGN_S);

  always_comb begin
    for (int b = 0; b < XW / 8; b++) begin
      w_ex2_merged[b*8 +: 8] = r_ex2_fwd_be[b] ? r_ex2_fwd_data[b*8 +: 8]
                                               : i_mem_rd_data[b*8 +: 8];
    end
    w_ex2_shifted = w_ex2_merged >> {r_ex2_addr[1:0], 3'b000};
    case (r_ex2_ctrl.size)
      lsu_pkg::SIZE_B: w_ex2_result = {{(XW-8){w_ex2_sx & w_ex2_shifted[7]}},
                                       w_ex2_shifted[7:0]};
      lsu_pkg::SIZE_H: w_ex2_result = {{(XW-16){w_ex2_sx & w_ex2_shifted[15]}},
                                       w_ex2_shifted[15:0]};
      default:         w_ex2_result = w_ex2_shifted;
    endcase
  end

  // Upper address bits would alias into the memory
  a_addr_in_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_ex1_valid && (r_ex1_ctrl.is_load || r_ex1_ctrl.is_store) |->
    w_ex1_addr[XW-1:AW+2] == '0);

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ns

module lsu_top #(
  parameter  int DMEM_WORDS = 64,
  parameter  int NUM_REGS   = 32,
  localparam int AW         = $clog2(DMEM_WORDS),
  localparam int XW         = riscv_isa_pkg::XLEN_W,
  localparam int RW         = riscv_isa_pkg::REG_ADDR_W
) (
  input  logic          i_clk,
  input  logic          i_reset_n,
  input  logic          i_issue_valid,
  input  logic [XW-1:0] i_issue_inst,
  input  logic          i_rf_wr_valid,
  input  logic [RW-1:0] i_rf_wr_addr,
  input  logic [XW-1:0] i_rf_wr_data,
  output logic          o_wb_valid,
  output logic [RW-1:0] o_wb_rd,
  output logic [XW-1:0] o_wb_data,
  output logic          o_exc_valid,
  output logic [XW-1:0] o_exc_addr
);

  logic [XW-1:0]      dec_inst;
  lsu_pkg::lsu_ctrl_t dec_ctrl;
  logic [XW-1:0]      dec_imm;
  logic [RW-1:0]      dec_rs1;
  logic [RW-1:0]      dec_rs2;
  logic [RW-1:0]      dec_rd;
  logic [RW-1:0]      rs1_addr;
  logic [XW-1:0]      rs1_data;
  logic [RW-1:0]      rs2_addr;
  logic [XW-1:0]      rs2_data;
  logic               mem_rd_en;
  logic [AW-1:0]      mem_rd_addr;
  logic [XW-1:0]      mem_rd_data;
  logic               mem_wr_en;
  logic [AW-1:0]      mem_wr_addr;
  logic [XW/8-1:0]    mem_wr_be;
  logic [XW-1:0]      mem_wr_data;

  lsu_decoder decoder_i (
    .i_inst (dec_inst),
    .o_ctrl (dec_ctrl),
    .o_imm  (dec_imm),
    .o_rs1  (dec_rs1),
    .o_rs2  (dec_rs2),
    .o_rd   (dec_rd)
  );

  lsu_regfile #(.NUM_REGS(NUM_REGS)) regfile_i (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_rd1_addr  (rs1_addr),
    .o_rd1_data  (rs1_data),
    .i_rd2_addr  (rs2_addr),
    .o_rd2_data  (rs2_data),
    .i_wr0_valid (o_wb_valid),
    .i_wr0_addr  (o_wb_rd),
    .i_wr0_data  (o_wb_data),
    .i_wr1_valid (i_rf_wr_valid), // Stand-in for the ALU pipe
    .i_wr1_addr  (i_rf_wr_addr),
    .i_wr1_data  (i_rf_wr_data)
  );

  lsu_dmem #(.DMEM_WORDS(DMEM_WORDS)) dmem_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_en   (mem_rd_en),
    .i_rd_addr (mem_rd_addr),
    .o_rd_data (mem_rd_data),
    .i_wr_en   (mem_wr_en),
    .i_wr_addr (mem_wr_addr),
    .i_wr_be   (mem_wr_be),
    .i_wr_data (mem_wr_data)
  );

  lsu_pipe #(.DMEM_WORDS(DMEM_WORDS)) pipe_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue_valid (i_issue_valid),
    .i_issue_inst  (i_issue_inst),
    .o_dec_inst    (dec_inst),
    .i_dec_ctrl    (dec_ctrl),
    .i_dec_imm     (dec_imm),
    .i_dec_rs1     (dec_rs1),
    .i_dec_rs2     (dec_rs2),
    .i_dec_rd      (dec_rd),
    .o_rs1_addr    (rs1_addr),
    .i_rs1_data    (rs1_data),
    .o_rs2_addr    (rs2_addr),
    .i_rs2_data    (rs2_data),
    .o_mem_rd_en   (mem_rd_en),
    .o_mem_rd_addr (mem_rd_addr),
    .i_mem_rd_data (mem_rd_data),
    .o_mem_wr_en   (mem_wr_en),
    .o_mem_wr_addr (mem_wr_addr),
    .o_mem_wr_be   (mem_wr_be),
    .o_mem_wr_data (mem_wr_data),
    .o_wb_valid    (o_wb_valid),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data),
    .o_exc_valid   (o_exc_valid),
    .o_exc_addr    (o_exc_addr)
  );

endmodule

/* include/lsu_tb_ref.svh */
`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

// Architectural state as seen in issue order
logic [riscv_isa_pkg::XLEN_W-1:0] ref_regs [32];
logic [7:0]                       ref_mem [logic [31:0]]; // Byte addressed

function automatic logic [31:0] encode_load(
  input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm
);
  return {imm, rs1, f3, rd, riscv_isa_pkg::OPC_LOAD};
endfunction

function automatic logic [31:0] encode_store(
  input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm
);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] effective_addr(input logic [4:0] rs1, input logic [11:0] imm);
  logic [31:0] base;
  base = (rs1 == '0) ? '0 : ref_regs[rs1];
  return base + {{20{imm[11]}}, imm};
endfunction

function automatic int access_bytes(input logic [2:0] f3);
  return (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
endfunction

function automatic bit is_misaligned(input logic [2:0] f3, input logic [31:0] addr);
  return (access_bytes(f3) == 2 && addr[0]) || (access_bytes(f3) == 4 && addr[1:0] != 2'b00);
endfunction

// Misaligned stores leave memory alone
function automatic void apply_store(input logic [2:0] f3, input logic [31:0] addr,
                                    input logic [31:0] data);
  if (is_misaligned(f3, addr)) begin
    return;
  end
  for (int i = 0; i < access_bytes(f3); i++) begin
    ref_mem[addr + i] = data[i*8 +: 8];
  end
endfunction

function automatic logic [31:0] predict_load(input logic [2:0] f3, input logic [31:0] addr);
  int          n = access_bytes(f3);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++) begin
    val[i*8 +: 8] = ref_mem[addr + i];
  end
  if (!f3[2] && n == 1) begin
    val[31:8] = {24{val[7]}};
  end else if (!f3[2] && n == 2) begin
    val[31:16] = {16{val[15]}};
  end
  return val;
endfunction

`endif

/* bench/lsu_tb.sv */
`timescale 1ns/1ns

module lsu_tb;

  typedef struct {
    int unsigned cyc;
    bit          exc;
    logic [4:0]  rd;
    logic [31:0] data;
  } exp_t;

  logic        i_clk = 1'b0;
  logic        i_reset_n;
  logic        i_issue_valid;
  logic [31:0] i_issue_inst;
  logic        i_rf_wr_valid;
  logic [4:0]  i_rf_wr_addr;
  logic [31:0] i_rf_wr_data;
  logic        o_wb_valid;
  logic [4:0]  o_wb_rd;
  logic [31:0] o_wb_data;
  logic        o_exc_valid;
  logic [31:0] o_exc_addr;

  int unsigned cycle_count = 0;
  logic [31:0] lcg_state   = 32'h81ddb714;
  string       test_name   = "reset";
  exp_t        exp_q [$];

  `include "lsu_tb_ref.svh"

  lsu_top #(.DMEM_WORDS(64), .NUM_REGS(32)) dut_i (.*);

  always #10 i_clk = ~i_clk;
  always @(posedge i_clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] reg_value(input logic [4:0] r);
    return (r == '0) ? '0 : ref_regs[r];
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error %s %s: expected %h, actual %h",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #2;
    i_issue_valid = 1'b0;
    i_rf_wr_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic seed_reg(input logic [4:0] r, input logic [31:0] value);
    next_cycle();
    i_rf_wr_valid = 1'b1;
    i_rf_wr_addr  = r;
    i_rf_wr_data  = value;
    if (r != '0) ref_regs[r] = value;
  endtask

  task automatic issue_load(input logic [2:0] f3, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr;
    exp_t        item;
    addr = effective_addr(rs1, imm);
    next_cycle();
    i_issue_valid = 1'b1;
    i_issue_inst  = encode_load(f3, rd, rs1, imm);
    item.cyc = cycle_count + 4; // Fixed 4-cycle latency
    item.rd  = rd;
    item.exc = is_misaligned(f3, addr);
    item.data = item.exc ? addr : predict_load(f3, addr);
    if (!item.exc && rd != '0) ref_regs[rd] = item.data;
    exp_q.push_back(item);
  endtask

  task automatic issue_store(input logic [2:0] f3, input logic [4:0] rs2,
                             input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr;
    exp_t        item;
    addr = effective_addr(rs1, imm);
    next_cycle();
    i_issue_valid = 1'b1;
    i_issue_inst  = encode_store(f3, rs2, rs1, imm);
    if (is_misaligned(f3, addr)) begin
      item = '{cycle_count + 4, 1'b1, 5'd0, addr};
      exp_q.push_back(item);
    end else begin
      apply_store(f3, addr, reg_value(rs2));
    end
  endtask

  // Wait for all results, then let trailing stores retire
  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    next_cycle();
    while (exp_q.size() != 0) begin
      if (n == max_cycles) begin
        fail_run($sformatf("Timeout: %0d results still missing after %0d cycles",
                           exp_q.size(), max_cycles));
      end else begin
        next_cycle();
        n++;
      end
    end
    idle(4);
  endtask

  task automatic compare_cycle();
    exp_t head;
    if (exp_q.size() != 0 && exp_q[0].cyc == cycle_count) begin
      head = exp_q.pop_front();
      check("wb_valid", !head.exc, o_wb_valid);
      check("exc_valid", head.exc, o_exc_valid);
      if (head.exc) begin
        check("exc_addr", head.data, o_exc_addr);
      end else begin
        check("wb_rd", head.rd, o_wb_rd);
        check("wb_data", head.data, o_wb_data);
      end
    end else begin
      check("wb_valid", 0, o_wb_valid); // Nothing due this cycle
      check("exc_valid", 0, o_exc_valid);
    end
  endtask

  always @(negedge i_clk) begin
    if (i_reset_n) compare_cycle();
  end

  initial begin
    logic [31:0] r;
    logic [2:0]  f3;
    int          off;
    logic [2:0]  ops [8];
    ops = '{riscv_isa_pkg::F3_B, riscv_isa_pkg::F3_H, riscv_isa_pkg::F3_W,
            riscv_isa_pkg::F3_BU, riscv_isa_pkg::F3_HU,
            riscv_isa_pkg::F3_B, riscv_isa_pkg::F3_H, riscv_isa_pkg::F3_W};
    i_reset_n     = 1'b0;
    i_issue_valid = 1'b0;
    i_issue_inst  = '0;
    i_rf_wr_valid = 1'b0;
    i_rf_wr_addr  = '0;
    i_rf_wr_data  = '0;
    foreach (ref_regs[i]) ref_regs[i] = '0;
    repeat (2) @(posedge i_clk);
    #2;
    i_reset_n = 1'b1;

    test_name = "round_trip";
    for (int b = 1; b <= 4; b++) seed_reg(b, 32'h20 + 32'h20 * b); // Bases 0x40 to 0xa0
    for (int w = 0; w < 64; w++) begin
      if (w % 8 == 0) for (int d = 8; d < 16; d++) seed_reg(d, lcg_next());
      issue_store(riscv_isa_pkg::F3_W, 8 + w % 8, 0, 12'(w * 4));
    end
    idle(3);
    for (int w = 0; w < 64; w++) begin
      issue_load(riscv_isa_pkg::F3_W, 16 + w % 8, 0, 12'(w * 4));
      idle(lcg_next() % 3);
    end
    drain(50);

    test_name = "subword";
    seed_reg(12, 32'h0000_80f1);
    seed_reg(13, 32'h0000_7f12);
    for (int k = 0; k < 4; k++) begin
      issue_store(riscv_isa_pkg::F3_B, (k % 2) ? 12 : 13, 1, 12'(k - 16));
      issue_load(riscv_isa_pkg::F3_B, 16, 1, 12'(k - 16));
      issue_load(riscv_isa_pkg::F3_BU, 17, 1, 12'(k - 16));
      issue_load(riscv_isa_pkg::F3_B, 18, 1, 12'(k - 12)); // Untouched word
      issue_load(riscv_isa_pkg::F3_BU, 19, 1, 12'(k - 12));
    end
    for (int k = 0; k < 4; k += 2) begin
      issue_store(riscv_isa_pkg::F3_H, (k == 0) ? 12 : 13, 1, 12'(k - 8));
      issue_load(riscv_isa_pkg::F3_H, 16, 1, 12'(k - 8));
      issue_load(riscv_isa_pkg::F3_HU, 17, 1, 12'(k - 8));
      issue_load(riscv_isa_pkg::F3_H, 18, 1, 12'(k - 4));
      issue_load(riscv_isa_pkg::F3_HU, 19, 1, 12'(k - 4));
    end
    drain(50);

    test_name = "forwarding";
    seed_reg(20, lcg_next());
    seed_reg(21, lcg_next());
    issue_store(riscv_isa_pkg::F3_W, 20, 2, 12'd0);
    issue_load(riscv_isa_pkg::F3_W, 22, 2, 12'd0);
    issue_store(riscv_isa_pkg::F3_B, 21, 2, 12'd1); // Partial lanes
    issue_load(riscv_isa_pkg::F3_W, 23, 2, 12'd0);
    issue_store(riscv_isa_pkg::F3_H, 21, 2, 12'd6);
    issue_load(riscv_isa_pkg::F3_BU, 24, 2, 12'd7);
    issue_store(riscv_isa_pkg::F3_B, 20, 2, 12'd8);
    issue_load(riscv_isa_pkg::F3_H, 25, 2, 12'd8);
    issue_store(riscv_isa_pkg::F3_H, 21, 2, 12'd12);
    issue_load(riscv_isa_pkg::F3_B, 26, 2, 12'd15); // Same word, other lane
    drain(50);

    test_name = "bypass";
    seed_reg(5, 32'h44);
    seed_reg(6, 32'h88);
    issue_store(riscv_isa_pkg::F3_W, 5, 0, 12'h010);
    issue_store(riscv_isa_pkg::F3_W, 6, 0, 12'h044);
    drain(50);
    seed_reg(5, '0);
    seed_reg(6, '0);
    issue_load(riscv_isa_pkg::F3_W, 5, 0, 12'h010);
    issue_load(riscv_isa_pkg::F3_W, 6, 5, 12'd0);   // From EX2
    issue_load(riscv_isa_pkg::F3_W, 7, 5, 12'd8);   // From EX3
    issue_load(riscv_isa_pkg::F3_W, 17, 6, 12'd0);
    issue_load(riscv_isa_pkg::F3_BU, 18, 6, 12'd5); // Via register file
    drain(50);

    test_name = "misaligned";
    issue_load(riscv_isa_pkg::F3_H, 21, 3, 12'd1);
    issue_load(riscv_isa_pkg::F3_W, 22, 3, 12'd2);
    issue_load(riscv_isa_pkg::F3_HU, 23, 3, 12'd3);
    issue_store(riscv_isa_pkg::F3_W, 20, 3, 12'd5);
    issue_store(riscv_isa_pkg::F3_H, 20, 3, 12'd9);
    issue_load(riscv_isa_pkg::F3_W, 24, 3, 12'd4);
    issue_load(riscv_isa_pkg::F3_W, 25, 3, 12'd8);
    drain(50);

    test_name = "random_mix";
    for (int i = 0; i < 300; i++) begin
      r   = lcg_next();
      f3  = ops[r[2:0]];
      off = int'(r[14:8]) - 64;
      if (r[19:16] != 4'd0) off = off & ~(access_bytes(f3) - 1); // Mostly aligned
      if (r[2:0] >= 3'd5) begin
        issue_store(f3, 8 + r[23:21], 1 + r[25:24], 12'(off));
      end else begin
        issue_load(f3, 8 + r[23:21], 1 + r[25:24], 12'(off));
      end
      if (r[27:26] == 2'd0) idle(1);
    end
    drain(50);

    $display("Regression passed");
    $finish;
  end

endmodule

/* build.f */
+incdir+include
hdl/riscv_isa_pkg.sv
hdl/lsu_pkg.sv
hdl/lsu_decoder.sv
hdl/lsu_regfile.sv
hdl/lsu_dmem.sv
hdl/lsu_pipe.sv
hdl/lsu_top.sv
bench/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - hdl/riscv_isa_pkg.sv
      - hdl/lsu_pkg.sv
      - hdl/lsu_decoder.sv
      - hdl/lsu_regfile.sv
      - hdl/lsu_dmem.sv
      - hdl/lsu_pipe.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/lsu_tb.sv
